/* sdf_fft.f */
src/sdf_fft_pkg.sv
src/sdf_delay_line.sv
src/r4_seq_ctl.sv
src/r4_butterfly.sv
src/r4_sdf_stage.sv
tests/sdf_fft_clk_gen.sv
tests/sdf_fft_tb.sv

/* src/r4_butterfly.sv */
`timescale 1ns/1ps

module r4_butterfly
	import sdf_fft_pkg::*;
(
	input  cplx_t a_i,
	input  cplx_t b_i,
	input  cplx_t c_i,
	input  cplx_t d_i,
	output cplx_t x0_o,
	output cplx_t x1_o,
	output cplx_t x2_o,
	output cplx_t x3_o
);

	// Two guard bits hold a sum of four full-scale parts
	typedef logic signed [sample_w+1:0] wide_t;

	function automatic wide_t ext(input logic signed [sample_w-1:0] v);
		return wide_t'(v);
	endfunction

	// Divide by four, the result always fits in sample_w bits
	function automatic logic signed [sample_w-1:0] scale(input wide_t s);
		wide_t t;
		t = s >>> 2;
		return t[sample_w-1:0];
	endfunction

	wide_t ar;
	wide_t ai;
	wide_t br;
	wide_t bi;
	wide_t cr;
	wide_t ci;
	wide_t dr;
	wide_t di;
	wide_t s0_re;
	wide_t s0_im;
	wide_t s1_re;
	wide_t s1_im;
	wide_t s2_re;
	wide_t s2_im;
	wide_t s3_re;
	wide_t s3_im;

	assign ar = ext(a_i.re);
	assign ai = ext(a_i.im);
	assign br = ext(b_i.re);
	assign bi = ext(b_i.im);
	assign cr = ext(c_i.re);
	assign ci = ext(c_i.im);
	assign dr = ext(d_i.re);
	assign di = ext(d_i.im);

	// X0 = a + b + c + d
	assign s0_re = ar + br + cr + dr;
	assign s0_im = ai + bi + ci + di;

	// X1 = a - jb - c + jd
	// -jb gives (bi, -br), +jd gives (-di, dr)
	assign s1_re = ar + bi - cr - di;
	assign s1_im = ai - br - ci + dr;

	// X2 = a - b + c - d
	assign s2_re = ar - br + cr - dr;
	assign s2_im = ai - bi + ci - di;

	// X3 = a + jb - c - jd
	assign s3_re = ar - bi - cr + di;
	assign s3_im = ai + br - ci - dr;

	assign x0_o = '{re: scale(s0_re), im: scale(s0_im)};
	assign x1_o = '{re: scale(s1_re), im: scale(s1_im)};
	assign x2_o = '{re: scale(s2_re), im: scale(s2_im)};
	assign x3_o = '{re: scale(s3_re), im: scale(s3_im)};

endmodule

/* src/r4_sdf_stage.sv */
`timescale 1ns/1ps

module r4_sdf_stage
	import sdf_fft_pkg::*;
#(
	parameter int fft_points = 256
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  in_valid_i,
	input  cplx_t in_data_i,
	output logic  in_ready_o,
	output logic  out_valid_o,
	output cplx_t out_data_o,
	input  logic  out_ready_i
);

	localparam int depth = fft_points / 4;

	logic         advance;
	frame_phase_e phase;
	logic         primed;
	logic [2:0]   line_en;
	cplx_t        line_d [3];
	cplx_t        line_q [3];
	cplx_t        x0;
	cplx_t        x1;
	cplx_t        x2;
	cplx_t        x3;
	cplx_t        out_sel;
	cplx_t        out_data_q;
	logic         out_valid_q;

	// Whole stage stalls while the output register is full and blocked
	assign in_ready_o = !out_valid_q || out_ready_i;
	assign advance    = in_valid_i && in_ready_o;

	r4_seq_ctl #(
		.fft_points(fft_points)
	) u_seq_ctl (
		.clk(clk),
		.rst_n(rst_n),
		.advance_i(advance),
		.phase_o(phase),
		.primed_o(primed)
	);

	// Load phases fill one line with raw input while compute refills all three with X1..X3
	always_comb begin
		line_en   = 3'b000;
		line_d[0] = in_data_i;
		line_d[1] = in_data_i;
		line_d[2] = in_data_i;
		case (phase)
			load0: line_en = 3'b001;
			load1: line_en = 3'b010;
			load2: line_en = 3'b100;
			compute: begin
				line_en   = 3'b111;
				line_d[0] = x1;
				line_d[1] = x2;
				line_d[2] = x3;
			end
			default: line_en = 3'b000;
		endcase
		line_en = line_en & {3{advance}};
	end

	for (genvar i = 0; i < 3; i++) begin : g_line
		sdf_delay_line #(
			.depth(depth)
		) u_line (
			.clk(clk),
			.rst_n(rst_n),
			.en_i(line_en[i]),
			.data_i(line_d[i]),
			.data_o(line_q[i])
		);
	end

	// Lines give x[n], x[n+N/4] and x[n+N/2] and the input gives x[n+3N/4]
	r4_butterfly u_butterfly (
		.a_i(line_q[0]),
		.b_i(line_q[1]),
		.c_i(line_q[2]),
		.d_i(in_data_i),
		.x0_o(x0),
		.x1_o(x1),
		.x2_o(x2),
		.x3_o(x3)
	);

	// Previous frame's X1..X3 drain while the next frame loads
	always_comb begin
		case (phase)
			load0:   out_sel = line_q[0];
			load1:   out_sel = line_q[1];
			load2:   out_sel = line_q[2];
			compute: out_sel = x0;
			default: out_sel = x0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			out_data_q <= out_sel;
		end
	end

	// First valid result is the X0 of sample 3N/4
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid_q <= 1'b0;
		end else if (advance) begin
			out_valid_q <= primed || (phase == compute);
		end else if (out_ready_i) begin
			out_valid_q <= 1'b0;
		end
	end

	assign out_valid_o = out_valid_q;
	assign out_data_o  = out_data_q;

	a_data_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid_o && !out_ready_i |=> $stable(out_data_o)
	) else $error("r4_sdf_stage: out_data_o changed while stalled");

	a_ready_when_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		!out_valid_o |-> in_ready_o
	) else $error("r4_sdf_stage: in_ready_o low with empty output");

endmodule

/* src/r4_seq_ctl.sv */
`timescale 1ns/1ps

module r4_seq_ctl
	import sdf_fft_pkg::*;
#(
	parameter int fft_points = 256
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         advance_i,
	output frame_phase_e phase_o,
	output logic         primed_o
);

	localparam int cnt_w = $clog2(fft_points);

	logic [cnt_w-1:0] cnt;
	logic             primed;

	// Top two counter bits must name the quarter exactly
	if (fft_points < 16 || (1 << cnt_w) != fft_points || (cnt_w % 2) != 0) begin : g_bad_points
		$error("r4_seq_ctl: fft_points %0d is not a power of four of at least 16",
			fft_points);
	end

	// Sample index within the frame
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (advance_i) begin
			if (cnt == cnt_w'(fft_points - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign phase_o = frame_phase_e'(cnt[cnt_w-1 -: 2]);

	// Delay lines hold butterfly results from here on
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			primed <= 1'b0;
		end else if (phase_o == compute) begin
			primed <= 1'b1;
		end
	end

	assign primed_o = primed;

	a_primed_sticky: assert property (
		@(posedge clk) disable iff (!rst_n)
		primed_o |=> primed_o
	) else $error("r4_seq_ctl: primed_o fell without reset");

endmodule

/* src/sdf_delay_line.sv */
`timescale 1ns/1ps

module sdf_delay_line
	import sdf_fft_pkg::*;
#(
	parameter int depth = 64
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  en_i,
	input  cplx_t data_i,
	output cplx_t data_o
);

	cplx_t sr [depth];

	// One position per enabled edge, the line holds still otherwise
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++) begin
				sr[i] <= '0;
			end
		end else if (en_i) begin
			sr[0] <= data_i;
			for (int i = 1; i < depth; i++) begin
				sr[i] <= sr[i-1];
			end
		end
	end

	// Oldest stored sample
	assign data_o = sr[depth-1];

	// An unknown enable would let the three lines slip against each other
	a_en_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(en_i)
	) else $error("sdf_delay_line: en_i is unknown");

endmodule

/* src/sdf_fft_pkg.sv */
package sdf_fft_pkg;

	// Width of one real or imaginary part
	localparam int sample_w = 16;

	// One complex sample, real part in the upper half
	typedef struct packed {
		logic signed [sample_w-1:0] re;
		logic signed [sample_w-1:0] im;
	} cplx_t;

	// Quarter of the frame now arriving at the stage input
	typedef enum logic [1:0] {
		load0   = 2'd0,
		load1   = 2'd1,
		load2   = 2'd2,
		compute = 2'd3
	} frame_phase_e;

endpackage

/* tests/sdf_fft_clk_gen.sv */
`timescale 1ns/1ps

module sdf_fft_clk_gen #(
	parameter real period       = 20.0,
	parameter int  reset_cycles = 3
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(period / 2.0) clk_o = ~clk_o;
	end

	// Released on a falling edge, away from the sampling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (reset_cycles) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

/* tests/sdf_fft_tb.sv */
`timescale 1ns/1ps

module sdf_fft_tb
	import sdf_fft_pkg::*;
();

	localparam int  npts           = 256;
	localparam int  n_frames       = 12;
	localparam real period         = 20.0;
	localparam int  timeout_cycles = n_frames * npts * 4 + 100;
	localparam int  prime_len      = 3 * npts / 4;

	// Frame contents
	localparam int mode_rand = 0;
	localparam int mode_zero = 1;
	localparam int mode_min  = 2;
	localparam int mode_max  = 3;

	logic  clk;
	logic  rst_n;
	logic  in_valid = 1'b0;
	cplx_t in_data = '0;
	logic  in_ready;
	logic  out_valid;
	cplx_t out_data;
	logic  out_ready = 1'b1;

	int    seed = 32'hdbff;
	cplx_t exp_q [$];
	cplx_t exp_head = '0;
	logic  exp_avail = 1'b0;
	int    in_count = 0;
	int    out_count = 0;
	int    err_count = 0;
	int    errs_at_start = 0;
	int    n_tests = 0;
	int    n_pass = 0;
	logic  rst_check = 1'b0;
	logic  gap_check = 1'b0;

	sdf_fft_clk_gen #(
		.period(period),
		.reset_cycles(3)
	) u_clk_gen (
		.clk_o(clk),
		.rst_n_o(rst_n)
	);

	r4_sdf_stage #(
		.fft_points(npts)
	) uut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid_i(in_valid),
		.in_data_i(in_data),
		.in_ready_o(in_ready),
		.out_valid_o(out_valid),
		.out_data_o(out_data),
		.out_ready_i(out_ready)
	);

	function automatic void refresh_head();
		exp_avail = exp_q.size() > 0;
		exp_head  = exp_avail ? exp_q[0] : '0;
	endfunction

	// X[k] = sum over m of x_m * (-j)^(m*k), divided by four
	function automatic cplx_t ref_point(input cplx_t a, input cplx_t b, input cplx_t c,
			input cplx_t d, input int k);
		cplx_t x [4];
		cplx_t r;
		int    acc_re;
		int    acc_im;
		int    re;
		int    im;
		int    t;
		x[0]   = a;
		x[1]   = b;
		x[2]   = c;
		x[3]   = d;
		acc_re = 0;
		acc_im = 0;
		for (int m = 0; m < 4; m++) begin
			re = x[m].re;
			im = x[m].im;
			for (int p = 0; p < (m * k) % 4; p++) begin
				t  = re;
				re = im;
				im = -t;
			end
			acc_re += re;
			acc_im += im;
		end
		r.re = sample_w'(acc_re >>> 2);
		r.im = sample_w'(acc_im >>> 2);
		return r;
	endfunction

	// Stage emits all X0 of a frame, then X1, X2 and X3 in index order
	task automatic push_frame(input cplx_t smp [npts]);
		int q;
		q = npts / 4;
		for (int k = 0; k < 4; k++) begin
			for (int n = 0; n < q; n++) begin
				exp_q.push_back(ref_point(smp[n], smp[n+q], smp[n+2*q], smp[n+3*q], k));
			end
		end
		refresh_head();
	endtask

	task automatic send_frame(input int mode, input bit bubbles, input bit stall);
		cplx_t smp [npts];
		int    n;
		int    draw;
		bit    pending;
		bit    first;
		for (int i = 0; i < npts; i++) begin
			case (mode)
				mode_zero: smp[i] = '0;
				mode_min:  smp[i] = '{re: 16'h8000, im: 16'h8000};
				mode_max:  smp[i] = '{re: 16'h7fff, im: 16'h7fff};
				default:   smp[i] = cplx_t'($random(seed));
			endcase
		end
		n       = 0;
		pending = 1'b0;
		first   = 1'b1;
		while (n < npts) begin
			@(negedge clk);
			if (first) begin
				push_frame(smp);
				first = 1'b0;
			end
			draw = $random(seed);
			// A raised valid stays up until the sample is taken
			in_valid  = pending || !bubbles || draw[1:0] != 2'b00;
			out_ready = !stall || draw[3:2] != 2'b00;
			in_data   = smp[n];
			@(posedge clk);
			if (in_valid && in_ready) begin
				n++;
				pending = 1'b0;
			end else begin
				pending = in_valid;
			end
		end
	endtask

	task automatic drain();
		@(negedge clk);
		in_valid  = 1'b0;
		out_ready = 1'b1;
		while (out_valid) @(negedge clk);
	endtask

	// Last frame's X1..X3 stay in the lines until more input arrives
	task automatic check_counts();
		assert (out_count == in_count - prime_len) else begin
			err_count++;
			$display("%0d outputs seen after %0d accepted inputs, %0d expected",
				out_count, in_count, in_count - prime_len);
		end
		assert (exp_q.size() == prime_len) else begin
			err_count++;
			$display("%0d expected outputs still waiting instead of %0d",
				exp_q.size(), prime_len);
		end
	endtask

	task automatic begin_test();
		errs_at_start = err_count;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (err_count == errs_at_start) begin
			n_pass++;
			$display("test %0d %s: pass", n_tests, name);
		end else begin
			$display("test %0d %s: %0d errors", n_tests, name, err_count - errs_at_start);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			in_count  <= 0;
			out_count <= 0;
		end else begin
			if (in_valid && in_ready) begin
				in_count <= in_count + 1;
			end
			if (out_valid && out_ready) begin
				out_count <= out_count + 1;
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
					refresh_head();
				end
			end
		end
	end

	a_reset_idle: assert property (
		@(posedge clk) rst_check |-> !out_valid && in_ready
	) else begin
		err_count++;
		$display("output valid or input not ready while idle around reset");
	end

	a_expected_left: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && out_ready |-> exp_avail
	) else begin
		err_count++;
		$display("output transfer with no expected value left");
	end

	a_data_re: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && out_ready && exp_avail |-> out_data.re == exp_head.re
	) else begin
		err_count++;
		$display("FAILED out_data_o.re expected %h got %h",
			$sampled(exp_head.re), $sampled(out_data.re));
	end

	a_data_im: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && out_ready && exp_avail |-> out_data.im == exp_head.im
	) else begin
		err_count++;
		$display("FAILED out_data_o.im expected %h got %h",
			$sampled(exp_head.im), $sampled(out_data.im));
	end

	a_no_early_out: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_count <= prime_len |-> !out_valid
	) else begin
		err_count++;
		$display("valid output before input sample %0d", prime_len);
	end

	a_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid && in_ready && in_count >= prime_len |=> out_valid
	) else begin
		err_count++;
		$display("no valid output one cycle after an accepted input");
	end

	a_no_gap: assert property (
		@(posedge clk) disable iff (!rst_n)
		gap_check |-> out_valid
	) else begin
		err_count++;
		$display("gap in the output stream during continuous input");
	end

	a_ready_rule: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_ready == !(out_valid && !out_ready)
	) else begin
		err_count++;
		$display("input ready does not follow the output stall");
	end

	a_stall_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	) else begin
		err_count++;
		$display("output dropped or changed while the sink was stalling");
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", timeout_cycles);
		$display("tests failed");
		$finish;
	end

	initial begin
		begin_test();
		@(negedge clk);
		rst_check = 1'b1;
		wait (rst_n);
		repeat (4) @(negedge clk);
		rst_check = 1'b0;
		end_test("reset state");

		begin_test();
		send_frame(mode_rand, 1'b0, 1'b0);
		send_frame(mode_zero, 1'b0, 1'b0);
		drain();
		check_counts();
		end_test("single frame");

		begin_test();
		send_frame(mode_rand, 1'b0, 1'b0);
		gap_check = 1'b1;
		send_frame(mode_rand, 1'b0, 1'b0);
		send_frame(mode_rand, 1'b0, 1'b0);
		gap_check = 1'b0;
		drain();
		check_counts();
		end_test("continuous frames");

		begin_test();
		send_frame(mode_rand, 1'b1, 1'b0);
		send_frame(mode_rand, 1'b1, 1'b0);
		drain();
		check_counts();
		end_test("input bubbles");

		begin_test();
		send_frame(mode_rand, 1'b0, 1'b1);
		send_frame(mode_rand, 1'b0, 1'b1);
		drain();
		check_counts();
		end_test("back-pressure");

		begin_test();
		send_frame(mode_min, 1'b0, 1'b0);
		send_frame(mode_max, 1'b0, 1'b0);
		send_frame(mode_zero, 1'b0, 1'b0);
		drain();
		check_counts();
		end_test("full-scale input");

		$display("summary: %0d passed, %0d failed, %0d errors",
			n_pass, n_tests - n_pass, err_count);
		if (err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
